// File: fx_apb_regs.sv
// ==============================
// APB3 slave for the Q16.16 unit
// RESULT reads and CMD writes hold pready low until the unit is idle
// Writes to RESULT and STATUS are accepted and ignored
// Unmapped addresses answer with pslverr and change nothing
// ==============================
`timescale 1ns/100ps
`default_nettype none
`include "fx_fpu_macros.svh"

module fx_apb_regs import fx_fpu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [`FX_ADDR_W-1:0] paddr,
	input  logic [`FX_W-1:0]      pwdata,
	output logic [`FX_W-1:0]      prdata,
	output logic                  pready,
	output logic                  pslverr,
	output fx_operands_t          ops,
	output fx_cmd_t               cmd,
	output logic                  start,
	input  fx_status_t            status,
	input  logic [`FX_W-1:0]      result
);

	logic access;
	logic pending;
	logic stall;
	logic wr_done;
	logic sel_cmd;
	logic sel_res;
	logic mapped;

	// ==============================
	// Address decode and handshake
	// ==============================
	assign access  = psel && penable;
	assign sel_cmd = (paddr == `FX_REG_CMD);
	assign sel_res = (paddr == `FX_REG_RESULT);
	assign mapped  = paddr inside {`FX_REG_A, `FX_REG_B, `FX_REG_C,
		`FX_REG_CMD, `FX_REG_RESULT, `FX_REG_STATUS};

	// The start cycle counts as busy, retire only raises busy one edge later
	assign pending = status.busy || start;
	assign stall   = pending && ((sel_res && !pwrite) || (sel_cmd && pwrite));
	assign pready  = access && !stall;
	assign pslverr = access && !mapped;
	assign wr_done = pready && pwrite;

	// ==============================
	// Register file and launch pulse
	// ==============================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ops   <= '0;
			cmd   <= '0;
			start <= 1'b0;
		end else begin
			// Launch goes out one cycle after the CMD write completes
			start <= wr_done && sel_cmd;
			if (wr_done) begin
				case (paddr)
					`FX_REG_A:   ops.a <= pwdata;
					`FX_REG_B:   ops.b <= pwdata;
					`FX_REG_C:   ops.c <= pwdata;
					`FX_REG_CMD: cmd   <= fx_cmd_t'(pwdata[$bits(fx_cmd_t)-1:0]);
					default:     ;
				endcase
			end
		end
	end

	// Read mux, only sampled by the master when pready is high
	always_comb begin
		case (paddr)
			`FX_REG_A:      prdata = ops.a;
			`FX_REG_B:      prdata = ops.b;
			`FX_REG_C:      prdata = ops.c;
			`FX_REG_CMD:    prdata = `FX_W'(cmd);
			`FX_REG_RESULT: prdata = result;
			`FX_REG_STATUS: prdata = `FX_W'(status);
			default:        prdata = '0;
		endcase
	end

	// The CMD stall must keep a new launch away from a running operation
	a_start_idle: assert property (@(posedge clk) disable iff (rst)
		$rose(start) |-> !status.busy);

endmodule

`default_nettype wire

// File: fx_cordic.sv
// ==============================
// Iterative rotation-mode CORDIC for sine and cosine
// Angle is Q16.16 radians and must lie within +-pi/2
// Out-of-range angles return 0 with range_err after one cycle
// Results are truncated whatever the rounding mode
// ==============================
`timescale 1ns/100ps
`default_nettype none
`include "fx_fpu_macros.svh"

module fx_cordic import fx_fpu_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	input  fx_cmd_t          cmd,
	input  logic [`FX_W-1:0] angle,
	output fx_unit_out_t     out
);

	localparam int W     = `FX_W;
	localparam int ITERS = `FX_CORDIC_ITERS;
	localparam int IW    = $clog2(ITERS);
	localparam logic [IW-1:0] LAST = IW'(ITERS - 1);

	logic                go;
	logic                out_of_range;
	logic                run;
	logic                done;
	logic                rerr;
	logic [IW-1:0]       iter;
	logic signed [W-1:0] x, y, z;
	logic signed [W-1:0] x_sh, y_sh;
	logic signed [W-1:0] x_next, y_next, z_next;

	assign go           = start && (cmd.op inside {OP_SIN, OP_COS});
	assign out_of_range = ($signed(angle) > FX_HALF_PI) || ($signed(angle) < -FX_HALF_PI);

	// ==============================
	// One micro-rotation
	// ==============================
	assign x_sh = x >>> iter;
	assign y_sh = y >>> iter;

	// Rotate toward z = 0, direction taken from the sign of z
	always_comb begin
		if (!z[W-1]) begin
			x_next = x - y_sh;
			y_next = y + x_sh;
			z_next = z - fx_atan_table[iter];
		end else begin
			x_next = x + y_sh;
			y_next = y - x_sh;
			z_next = z + fx_atan_table[iter];
		end
	end

	// ==============================
	// Sequencing
	// ==============================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			run  <= 1'b0;
			done <= 1'b0;
			rerr <= 1'b0;
			iter <= '0;
		end else begin
			done <= 1'b0;
			if (go) begin
				// A bad angle skips the iterations and reports at once
				run  <= !out_of_range;
				done <= out_of_range;
				rerr <= out_of_range;
				iter <= '0;
			end else if (run) begin
				iter <= iter + 1'b1;
				if (iter == LAST) begin
					run  <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// x starts at the inverse gain so the final vector has unit length
	always_ff @(posedge clk) begin
		if (go) begin
			x <= out_of_range ? '0 : FX_CORDIC_GAIN;
			y <= '0;
			z <= $signed(angle);
		end else if (run) begin
			x <= x_next;
			y <= y_next;
			z <= z_next;
		end
	end

	// x and y hold zero after a range error, so the value is zero too
	assign out = '{
		valid:     done,
		value:     (cmd.op == OP_SIN) ? y : x,
		overflow:  1'b0,
		range_err: rerr
	};

	a_no_restart: assert property (@(posedge clk) disable iff (rst)
		start |-> !run);

endmodule

`default_nettype wire

// File: fx_fma_pipe.sv
// ==============================
// Three-stage Q16.16 multiply-add for FMA, FMS, FMUL and FADD
// Accepts a new start on every cycle
// Round to nearest rounds ties upward, overflow saturates
// ==============================
`timescale 1ns/100ps
`default_nettype none
`include "fx_fpu_macros.svh"

module fx_fma_pipe import fx_fpu_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         start,
	input  fx_cmd_t      cmd,
	input  fx_operands_t ops,
	output fx_unit_out_t out
);

	localparam int W    = `FX_W;
	localparam int FRAC = `FX_FRAC;
	localparam logic signed [W-1:0]     ONE  = 1 <<< FRAC;
	localparam logic signed [W-1:0]     MAXV = {1'b0, {(W-1){1'b1}}};
	localparam logic signed [W-1:0]     MINV = {1'b1, {(W-1){1'b0}}};
	localparam logic signed [2*W+1:0]   HALF = 1 <<< (FRAC-1);

	logic                    go;
	logic signed [W-1:0]     factor_b;
	logic signed [2*W-1:0]   c_wide;
	logic signed [2*W-1:0]   addend;
	logic signed [2*W+1:0]   bias;
	logic signed [2*W+1:0]   shifted;
	logic                    fits;
	logic                    v1, v2, v3;
	logic signed [W-1:0]     s1_a, s1_b;
	logic signed [2*W-1:0]   s1_add;
	fx_rm_e                  s1_rm;
	logic signed [2*W+1:0]   s2_sum;
	logic signed [W-1:0]     s3_val;
	logic                    s3_ovf;

	assign go = start && (cmd.op inside {OP_FMA, OP_FMS, OP_FMUL, OP_FADD});

	// FADD multiplies a by one, FMUL adds nothing, FMS subtracts c
	// The addend sits at the product scale of 2*FRAC fraction bits
	assign factor_b = (cmd.op == OP_FADD) ? ONE : $signed(ops.b);
	assign c_wide   = $signed(ops.c);
	always_comb begin
		case (cmd.op)
			OP_FMUL: addend = '0;
			OP_FMS:  addend = -(c_wide <<< FRAC);
			default: addend = c_wide <<< FRAC;
		endcase
	end

	always_comb begin
		if (s1_rm == RM_NEAR)
			bias = HALF;
		else
			bias = '0;
	end

	// Back to FRAC fraction bits, then check that the top bits are sign copies
	assign shifted = s2_sum >>> FRAC;
	assign fits    = (&shifted[2*W+1:W-1]) || !(|shifted[2*W+1:W-1]);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
		end else begin
			v1 <= go;
			v2 <= v1;
			v3 <= v2;
		end
	end

	always_ff @(posedge clk) begin
		if (go) begin
			s1_a   <= $signed(ops.a);
			s1_b   <= factor_b;
			s1_add <= addend;
			s1_rm  <= cmd.rm;
		end
		// Full product plus aligned addend plus rounding bias
		if (v1)
			s2_sum <= s1_a * s1_b + s1_add + bias;
		if (v2) begin
			s3_val <= fits ? shifted[W-1:0] : (shifted[2*W+1] ? MINV : MAXV);
			s3_ovf <= !fits;
		end
	end

	assign out = '{valid: v3, value: s3_val, overflow: s3_ovf, range_err: 1'b0};

	a_fma_latency: assert property (@(posedge clk) disable iff (rst)
		go |-> ##(`FX_FMA_STAGES) out.valid);

endmodule

`default_nettype wire

// File: fx_fpu.f
+incdir+.
fx_fpu_pkg.sv
fx_apb_regs.sv
fx_fma_pipe.sv
fx_cordic.sv
fx_retire.sv
fx_fpu_top.sv
tb_fx_checker.sv
tb_fx_fpu.sv

// File: fx_fpu_macros.svh
// ==============================
// Global sizes and the APB register map of the Q16.16 unit
// Register offsets are byte addresses and must stay FX_ADDR_W bits wide
// FX_CORDIC_ITERS must match the length of the arctangent table
// ==============================
`ifndef FX_FPU_MACROS_SVH
`define FX_FPU_MACROS_SVH

// Word width and the position of the binary point
`define FX_W            32
`define FX_FRAC         16

// Number of register stages in the multiply-add pipeline
`define FX_FMA_STAGES   3

// One CORDIC micro-rotation per clock
`define FX_CORDIC_ITERS 16

// APB address width and register offsets
`define FX_ADDR_W       8
`define FX_REG_A        8'h00
`define FX_REG_B        8'h04
`define FX_REG_C        8'h08
`define FX_REG_CMD      8'h0C
`define FX_REG_RESULT   8'h10
`define FX_REG_STATUS   8'h14

`endif

// File: fx_fpu_pkg.sv
// ==============================
// Shared types and constants of the Q16.16 unit
// Values are signed two's complement with FX_FRAC fraction bits
// The arctangent table and the gain are the exact CORDIC constants
// ==============================
`default_nettype none
`include "fx_fpu_macros.svh"

package fx_fpu_pkg;

	// Opcode field of the CMD register, codes 6 and 7 are unused
	typedef enum logic [2:0] {
		OP_FMA  = 3'd0,
		OP_FMS  = 3'd1,
		OP_FMUL = 3'd2,
		OP_FADD = 3'd3,
		OP_SIN  = 3'd4,
		OP_COS  = 3'd5
	} fx_op_e;

	// Truncate drops the low bits, nearest adds half an LSB first
	typedef enum logic {
		RM_TRUNC = 1'b0,
		RM_NEAR  = 1'b1
	} fx_rm_e;

	// Low four bits of CMD, op in [3:1] and rm in [0]
	typedef struct packed {
		fx_op_e op;
		fx_rm_e rm;
	} fx_cmd_t;

	typedef struct packed {
		logic signed [`FX_W-1:0] a;
		logic signed [`FX_W-1:0] b;
		logic signed [`FX_W-1:0] c;
	} fx_operands_t;

	// Common result format of both arithmetic units
	typedef struct packed {
		logic            valid;
		logic [`FX_W-1:0] value;
		logic            overflow;
		logic            range_err;
	} fx_unit_out_t;

	// STATUS register, busy in bit 2
	typedef struct packed {
		logic busy;
		logic overflow;
		logic range_err;
	} fx_status_t;

	// atan(2^-i) in Q16.16, rounded to nearest
	localparam logic signed [`FX_W-1:0] fx_atan_table [`FX_CORDIC_ITERS] = '{
		32'sd51472, 32'sd30386, 32'sd16055, 32'sd8150,
		32'sd4091,  32'sd2047,  32'sd1024,  32'sd512,
		32'sd256,   32'sd128,   32'sd64,    32'sd32,
		32'sd16,    32'sd8,     32'sd4,     32'sd2
	};

	// Inverse CORDIC gain 0.6072529 and pi/2, both in Q16.16
	localparam logic signed [`FX_W-1:0] FX_CORDIC_GAIN = 32'sd39797;
	localparam logic signed [`FX_W-1:0] FX_HALF_PI     = 32'sd102944;

endpackage

`default_nettype wire

// File: fx_fpu_top.sv
// ==============================
// Q16.16 arithmetic unit behind an APB3 slave
// One operation in flight, completion is busy falling in STATUS
// ==============================
`timescale 1ns/100ps
`default_nettype none
`include "fx_fpu_macros.svh"

module fx_fpu_top import fx_fpu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [`FX_ADDR_W-1:0] paddr,
	input  logic [`FX_W-1:0]      pwdata,
	output logic [`FX_W-1:0]      prdata,
	output logic                  pready,
	output logic                  pslverr
);

	fx_operands_t     ops;
	fx_cmd_t          cmd;
	logic             start;
	fx_status_t       status;
	logic [`FX_W-1:0] result;
	fx_unit_out_t     fma_out;
	fx_unit_out_t     cordic_out;

	fx_apb_regs u_regs (
		.clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr,
		.ops, .cmd, .start, .status, .result
	);

	// Both units see every launch and filter on the opcode
	fx_fma_pipe u_fma (.clk, .rst, .start, .cmd, .ops, .out(fma_out));

	fx_cordic u_cordic (.clk, .rst, .start, .cmd, .angle(ops.a), .out(cordic_out));

	fx_retire u_retire (
		.clk, .rst, .start, .cmd, .fma_out, .cordic_out, .result, .status
	);

endmodule

`default_nettype wire

// File: fx_retire.sv
// ==============================
// Retire stage of the Q16.16 unit
// Takes the result of the unit that owns the current opcode
// cmd must stay stable while busy is set
// ==============================
`timescale 1ns/100ps
`default_nettype none
`include "fx_fpu_macros.svh"

module fx_retire import fx_fpu_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	input  fx_cmd_t          cmd,
	input  fx_unit_out_t     fma_out,
	input  fx_unit_out_t     cordic_out,
	output logic [`FX_W-1:0] result,
	output fx_status_t       status
);

	logic         trig_op;
	logic         known_op;
	logic         busy;
	logic         ovf;
	logic         rerr;
	fx_unit_out_t owner;

	assign trig_op  = (cmd.op == OP_SIN) || (cmd.op == OP_COS);
	assign known_op = trig_op || (cmd.op inside {OP_FMA, OP_FMS, OP_FMUL, OP_FADD});
	assign owner    = trig_op ? cordic_out : fma_out;

	// An unused opcode never sets busy, otherwise nothing would ever retire it
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy   <= 1'b0;
			ovf    <= 1'b0;
			rerr   <= 1'b0;
			result <= '0;
		end else if (start) begin
			busy <= known_op;
		end else if (busy && owner.valid) begin
			// Flags describe the last retired operation only
			busy   <= 1'b0;
			result <= owner.value;
			ovf    <= owner.overflow;
			rerr   <= owner.range_err;
		end
	end

	assign status = '{busy: busy, overflow: ovf, range_err: rerr};

	// With one operation in flight only one unit can be finishing
	a_one_valid: assert property (@(posedge clk) disable iff (rst)
		!(fma_out.valid && cordic_out.valid));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it into sim.log and looks for the pass line
verilator --binary --timing --assert -Wno-fatal --top-module tb_fx_fpu \
	-f fx_fpu.f -o sim_fx_fpu &&
./obj_dir/sim_fx_fpu > sim.log 2>&1 &&
grep -q "^=== PASS ===$" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see sim.log"; exit 1; }

// File: tb_fx_checker.sv
// ==============================
// Bus monitor and scoreboard for the Q16.16 unit
// Completed APB transfers are sampled on the falling edge
// Expected values come from bit-exact reference models
// Only RESULT and idle STATUS reads are compared with the models
// ==============================
`timescale 1ns/100ps
`default_nettype none
`include "fx_fpu_macros.svh"

module tb_fx_checker import fx_fpu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [`FX_ADDR_W-1:0] paddr,
	input  logic [`FX_W-1:0]      pwdata,
	input  logic [`FX_W-1:0]      prdata,
	input  logic                  pready,
	input  logic                  pslverr,
	input  logic [2:0]            test_id,
	output int                    errors,
	output int                    checks
);

	// pi/2 in Q16.16, rounded
	localparam int HALF_PI_Q = 102944;

	string test_names [8] = '{"arith", "saturate", "trig", "range", "stall", "unmapped",
		"spare6", "spare7"};

	logic [`FX_W-1:0] sh_a, sh_b, sh_c, exp_val;
	fx_cmd_t          sh_cmd;
	logic             exp_ovf, exp_rerr, have_exp, trig, mapped;
	logic [`FX_W:0]   ref_out;
	int               cycle, cmd_ok, stall, lat;

	assign mapped = paddr inside {`FX_REG_A, `FX_REG_B, `FX_REG_C,
		`FX_REG_CMD, `FX_REG_RESULT, `FX_REG_STATUS};

	// ==============================
	// Reference models
	// ==============================
	// Multiply-add on 64-bit integers that returns {overflow, value}
	function automatic logic [`FX_W:0] fx_ref_fma(input fx_cmd_t op_cmd,
		input logic [`FX_W-1:0] a, input logic [`FX_W-1:0] b,
		input logic [`FX_W-1:0] c);
		longint fb;
		longint acc;
		fb = (op_cmd.op == OP_FADD) ? (64'sd1 <<< `FX_FRAC) : longint'($signed(b));
		acc = longint'($signed(a)) * fb;
		// The addend is lifted to the product scale before the sum
		case (op_cmd.op)
			OP_FMUL: ;
			OP_FMS:  acc = acc - (longint'($signed(c)) <<< `FX_FRAC);
			default: acc = acc + (longint'($signed(c)) <<< `FX_FRAC);
		endcase
		if (op_cmd.rm == RM_NEAR)
			acc = acc + (64'sd1 <<< (`FX_FRAC - 1));
		acc = acc >>> `FX_FRAC;
		if (acc > 64'sd2147483647)
			return {1'b1, 32'h7fff_ffff};
		if (acc < -64'sd2147483648)
			return {1'b1, 32'h8000_0000};
		return {1'b0, 32'(acc)};
	endfunction

	// Rotation-mode CORDIC that returns {range_err, value}
	function automatic logic [`FX_W:0] fx_ref_cordic(input fx_cmd_t op_cmd,
		input logic [`FX_W-1:0] angle);
		int x, y, z, t;
		z = $signed(angle);
		if (z > HALF_PI_Q || z < -HALF_PI_Q)
			return {1'b1, 32'h0};
		x = FX_CORDIC_GAIN;
		y = 0;
		for (int i = 0; i < `FX_CORDIC_ITERS; i++) begin
			t = x;
			if (z >= 0) begin
				x = x - (y >>> i);
				y = y + (t >>> i);
				z = z - fx_atan_table[i];
			end else begin
				x = x + (y >>> i);
				y = y - (t >>> i);
				z = z + fx_atan_table[i];
			end
		end
		return {1'b0, (op_cmd.op == OP_SIN) ? y : x};
	endfunction

	task automatic compare(input string what, input logic [`FX_W-1:0] exp,
		input logic [`FX_W-1:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAIL %s %s: expected %h, actual %h", test_names[test_id], what,
				exp, act);
		end
	endtask

	// ==============================
	// Transfer monitor
	// ==============================
	// pready and prdata are stable from the falling edge to the completing rising edge
	always @(negedge clk) begin
		if (rst) begin
			cycle = 0;
			stall = 0;
			cmd_ok = 0;
			have_exp = 1'b0;
			sh_a = '0;
			sh_b = '0;
			sh_c = '0;
			sh_cmd = '0;
			errors = 0;
			checks = 0;
		end else begin
			cycle++;
			if (psel && penable && !pready)
				stall++;
			if (psel && penable && pready) begin
				compare("pslverr", 32'(!mapped), 32'(pslverr));
				if (pwrite && mapped) begin
					case (paddr)
						`FX_REG_A: sh_a = pwdata;
						`FX_REG_B: sh_b = pwdata;
						`FX_REG_C: sh_c = pwdata;
						`FX_REG_CMD: begin
							// Busy must hold this write back until the previous op retired
							if (have_exp && cycle < cmd_ok) begin
								errors++;
								$display("CMD write finished at cycle %0d, %s (cycle %0d)",
									cycle, "before the previous operation could retire",
									cmd_ok);
							end
							sh_cmd = fx_cmd_t'(pwdata[$bits(fx_cmd_t)-1:0]);
							trig = sh_cmd.op inside {OP_SIN, OP_COS};
							ref_out = trig ? fx_ref_cordic(sh_cmd, sh_a) :
								fx_ref_fma(sh_cmd, sh_a, sh_b, sh_c);
							exp_val = ref_out[`FX_W-1:0];
							exp_ovf = !trig && ref_out[`FX_W];
							exp_rerr = trig && ref_out[`FX_W];
							// Start, unit latency, retire edge, then one access cycle
							if (!trig)
								lat = `FX_FMA_STAGES;
							else if (ref_out[`FX_W])
								lat = 1;
							else
								lat = `FX_CORDIC_ITERS + 1;
							cmd_ok = cycle + lat + 2;
							have_exp = 1'b1;
						end
						default: ;
					endcase
				end else if (!pwrite) begin
					case (paddr)
						`FX_REG_A:   compare("A readback", sh_a, prdata);
						`FX_REG_B:   compare("B readback", sh_b, prdata);
						`FX_REG_C:   compare("C readback", sh_c, prdata);
						`FX_REG_CMD: compare("CMD readback", 32'(sh_cmd), prdata);
						`FX_REG_RESULT: begin
							if (have_exp)
								compare("result", exp_val, prdata);
							if (test_id == 3'd4 && stall == 0) begin
								errors++;
								$display("%s %s", "RESULT read right after a CMD write",
									"completed without a stall");
							end
						end
						// Flags only mean something once the unit is idle
						`FX_REG_STATUS: if (have_exp && !prdata[2])
							compare("status", {29'b0, 1'b0, exp_ovf, exp_rerr}, prdata);
						default: ;
					endcase
				end
				stall = 0;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_fx_fpu.sv
// ==============================
// Testbench for the Q16.16 APB unit
// Stimulus changes 1 ns after the rising clock edge
// Each APB transfer and each busy poll gives up after TIMEOUT tries
// ==============================
`timescale 1ns/100ps
`default_nettype none
`include "fx_fpu_macros.svh"

module tb_fx_fpu import fx_fpu_pkg::*; ();

	localparam int TIMEOUT = 200;

	logic                  clk, rst, psel, penable, pwrite, pready, pslverr;
	logic [`FX_ADDR_W-1:0] paddr;
	logic [`FX_W-1:0]      pwdata, prdata, op_a, op_b, op_c, angle, rd_data;
	logic [2:0]            test_id;
	logic [31:0]           rng;
	int                    errors, checks, timeouts;
	int                    trig_angles [8] = '{0, 51472, -51472, 102900, -102900,
		102944, -102944, 25000};

	fx_fpu_top DUT (.clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr);

	tb_fx_checker u_checker (.clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .test_id, .errors, .checks);

	// 20 ns clock period
	always #10 clk = ~clk;

	// xorshift32 generator seeded once at time zero
	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// ==============================
	// APB master
	// ==============================
	task automatic apb_xfer(input logic wr, input logic [`FX_ADDR_W-1:0] addr,
		input logic [`FX_W-1:0] wdata, output logic [`FX_W-1:0] rdata);
		int   waited;
		logic done;
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		waited = 0;
		done = 1'b0;
		rdata = '0;
		// Sampled at the falling edge where nothing is changing
		while (!done && waited < TIMEOUT) begin
			@(negedge clk);
			done = pready;
			rdata = prdata;
			@(posedge clk);
			waited++;
		end
		#1;
		psel = 1'b0;
		penable = 1'b0;
		if (!done) begin
			timeouts++;
			$display("APB access to address %h never completed, %s %0d cycles",
				addr, "pready stayed low for", TIMEOUT);
		end
	endtask

	task automatic apb_write(input logic [`FX_ADDR_W-1:0] addr, input logic [`FX_W-1:0] data);
		logic [`FX_W-1:0] unused;
		apb_xfer(1'b1, addr, data, unused);
	endtask

	task automatic apb_read(input logic [`FX_ADDR_W-1:0] addr, output logic [`FX_W-1:0] data);
		apb_xfer(1'b0, addr, '0, data);
	endtask

	// Polls STATUS until busy is low
	task automatic wait_idle();
		logic [`FX_W-1:0] st;
		int               polls;
		polls = 0;
		st = 32'h4;
		while (st[2] && polls < TIMEOUT) begin
			apb_read(`FX_REG_STATUS, st);
			polls++;
		end
		if (st[2]) begin
			timeouts++;
			$display("Unit still busy after %0d STATUS polls", TIMEOUT);
		end
	endtask

	// Loads the operands, launches, reads RESULT at once and then the flags
	task automatic run_op(input logic [2:0] op, input logic rm, input logic [`FX_W-1:0] a,
		input logic [`FX_W-1:0] b, input logic [`FX_W-1:0] c);
		logic [`FX_W-1:0] rd;
		apb_write(`FX_REG_A, a);
		apb_write(`FX_REG_B, b);
		apb_write(`FX_REG_C, c);
		apb_write(`FX_REG_CMD, `FX_W'({op, rm}));
		apb_read(`FX_REG_RESULT, rd);
		wait_idle();
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		clk = 1'b0;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		test_id = 3'd0;
		timeouts = 0;
		rng = 32'd84;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		// Every arithmetic opcode in both rounding modes, operands within +-128.0
		for (int n = 0; n < 32; n++) begin
			op_a = $signed(next_random()) >>> 8;
			op_b = $signed(next_random()) >>> 8;
			op_c = $signed(next_random()) >>> 8;
			run_op(3'(n % 4), 1'(n / 4), op_a, op_b, op_c);
		end

		// Positive and negative saturation, then a small sum clears the flag
		test_id = 3'd1;
		run_op(OP_FMUL, RM_TRUNC, 32'h7fff_0000, 32'h0010_0000, 32'h0);
		run_op(OP_FMA, RM_NEAR, 32'h8000_0000, 32'h0020_0000, 32'hffff_0000);
		run_op(OP_FADD, RM_TRUNC, 32'h7fff_ffff, 32'h0, 32'h7fff_ffff);
		run_op(OP_FMS, RM_NEAR, 32'h0002_0000, 32'h0003_0000, 32'h0001_0000);

		// Fixed corner angles first, random angles within +-pi/2 after them
		test_id = 3'd2;
		for (int n = 0; n < 16; n++) begin
			angle = (n < 8) ? trig_angles[n] : (next_random() % 32'd205889) - 32'd102944;
			run_op(OP_SIN, RM_TRUNC, angle, 32'h0, 32'h0);
			run_op(OP_COS, RM_NEAR, angle, 32'h0, 32'h0);
		end

		// Angles past pi/2 flag range_err, an in-range angle clears it
		test_id = 3'd3;
		run_op(OP_SIN, RM_TRUNC, 32'd102945, 32'h0, 32'h0);
		run_op(OP_COS, RM_TRUNC, -32'sd200000, 32'h0, 32'h0);
		run_op(OP_SIN, RM_NEAR, 32'h4000_0000, 32'h0, 32'h0);
		run_op(OP_COS, RM_TRUNC, 32'h0, 32'h0, 32'h0);

		// RESULT straight after CMD, then a CMD queued behind a running CORDIC
		test_id = 3'd4;
		run_op(OP_FMA, RM_NEAR, 32'h0001_8000, 32'hfffe_4000, 32'h0000_2000);
		apb_write(`FX_REG_A, 32'd40000);
		apb_write(`FX_REG_CMD, `FX_W'({OP_COS, RM_TRUNC}));
		apb_write(`FX_REG_CMD, `FX_W'({OP_FMUL, RM_NEAR}));
		apb_read(`FX_REG_RESULT, rd_data);
		wait_idle();

		// Unmapped accesses fail and leave the registers alone
		test_id = 3'd5;
		apb_write(8'h18, 32'hdead_beef);
		apb_write(8'h02, 32'h1234_5678);
		apb_read(8'h40, rd_data);
		apb_read(`FX_REG_A, rd_data);
		apb_read(`FX_REG_B, rd_data);
		apb_read(`FX_REG_C, rd_data);
		apb_read(`FX_REG_CMD, rd_data);

		$display("Summary: %0d checks, %0d mismatches, %0d timeouts", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0 && checks > 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
